// ==== verilog/tcdm_pkg.sv ====
// shared widths, vector typedefs and the tcdm request and response structs
package tcdm_pkg;

  // word address into the bank
  localparam int unsigned ADDR_W   = 10;
  // one memory word
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned BE_W     = DATA_W / 8;
  // tag width, enough for up to 8 request ports
  localparam int unsigned ID_W_MAX = 3;

  typedef logic [ADDR_W-1:0]   tcdm_addr_t;
  typedef logic [DATA_W-1:0]   tcdm_data_t;
  typedef logic [BE_W-1:0]     tcdm_be_t;
  typedef logic [ID_W_MAX-1:0] tcdm_id_t;

  // request channel, wen high selects a read
  typedef struct packed {
    logic       req;
    tcdm_addr_t add;
    logic       wen;
    tcdm_be_t   be;
    tcdm_data_t data;
  } tcdm_req_t;

  // response channel, r_id carries the reflected port tag
  typedef struct packed {
    logic       r_valid;
    tcdm_data_t r_data;
    tcdm_id_t   r_id;
  } tcdm_resp_t;

endpackage

// ==== verilog/tcdm_arb_ctrl.sv ====
// round-robin / forced-priority arbitration controller with a stable winner register
module tcdm_arb_ctrl #(
  parameter int unsigned NB_CHAN = 4,
  // channel index width, at least one bit
  parameter int unsigned CH_W    = (NB_CHAN > 1) ? $clog2(NB_CHAN) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          priority_force_i,
  input  logic [NB_CHAN-1:0][CH_W-1:0]  priority_i,
  input  logic [NB_CHAN-1:0]            req_i,
  input  logic                          out_hs_i,
  output logic [CH_W-1:0]               winner_o
);

  logic [CH_W-1:0]              counter_q;
  logic [CH_W-1:0]              winner_d, winner_q;
  logic [NB_CHAN-1:0][CH_W-1:0] rank_ch;
  logic                         hs_q;
  logic                         any_req_q;

  // counter steps once per accepted request on the bank side
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      counter_q <= '0;
    end else if (clear_i) begin
      counter_q <= '0;
    end else if (out_hs_i) begin
      if (counter_q == CH_W'(NB_CHAN - 1)) begin
        counter_q <= '0;
      end else begin
        counter_q <= counter_q + 1'b1;
      end
    end
  end

  // history of the previous cycle, used to unlock re-arbitration
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      winner_q  <= '0;
      hs_q      <= 1'b0;
      any_req_q <= 1'b0;
    end else if (clear_i) begin
      winner_q  <= '0;
      hs_q      <= 1'b0;
      any_req_q <= 1'b0;
    end else begin
      winner_q  <= winner_d;
      hs_q      <= out_hs_i;
      any_req_q <= |req_i;
    end
  end

  // rank r -> channel, rotated by the counter or taken from the table
  for (genvar r = 0; r < NB_CHAN; r++) begin : gen_rank
    assign rank_ch[r] = priority_force_i ? priority_i[r]
                                         : CH_W'((int'(counter_q) + r) % NB_CHAN);
  end

  // winner-takes-all
  // lowest-rank requester wins, scanned from the top so rank 0 is applied last
  // a pending request keeps its grant path until it is served
  always_comb begin
    winner_d = winner_q;
    if (hs_q || !any_req_q) begin
      // nobody requesting falls back to the counter
      winner_d = counter_q;
      for (int r = NB_CHAN - 1; r >= 0; r--) begin
        if (req_i[rank_ch[r]]) begin
          winner_d = rank_ch[r];
        end
      end
    end
  end

  // combinational, so grant follows req in the same cycle
  assign winner_o = winner_d;

endmodule

// ==== verilog/tcdm_port_steer.sv ====
// request selection with id stamping, grant fan-out and response routing by returned id
module tcdm_port_steer
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_CHAN = 4,
  parameter int unsigned CH_W    = (NB_CHAN > 1) ? $clog2(NB_CHAN) : 1
) (
  input  logic      [CH_W-1:0]    winner_i,
  input  tcdm_req_t [NB_CHAN-1:0] in_req_i,
  input  logic      [NB_CHAN-1:0] in_r_ready_i,
  output logic      [NB_CHAN-1:0] in_gnt_o,
  output tcdm_resp_t [NB_CHAN-1:0] in_resp_o,
  input  logic                    out_gnt_i,
  input  tcdm_resp_t              out_resp_i,
  output tcdm_req_t               out_req_o,
  output tcdm_id_t                out_id_o,
  output logic                    out_r_ready_o
);

  // request side
  // the winner's whole request goes out, req bit included
  assign out_req_o = in_req_i[winner_i];
  // tag is the winner's port number
  assign out_id_o  = tcdm_id_t'(winner_i);

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_port
    // only the winner sees the bank grant
    assign in_gnt_o[i] = (winner_i == CH_W'(i)) & in_req_i[i].req & out_gnt_i;

    // response side
    // valid goes to the owner of the tag, payload to everybody
    assign in_resp_o[i].r_valid = out_resp_i.r_valid &
                                  (out_resp_i.r_id == tcdm_id_t'(i));
    assign in_resp_o[i].r_data  = out_resp_i.r_data;
    assign in_resp_o[i].r_id    = out_resp_i.r_id;
  end

  // ready comes back from the port that owns the current response
  // a tag outside the port range reads as not ready
  always_comb begin
    out_r_ready_o = 1'b0;
    for (int i = 0; i < NB_CHAN; i++) begin
      if (out_resp_i.r_id == tcdm_id_t'(i)) begin
        out_r_ready_o = in_r_ready_i[i];
      end
    end
  end

endmodule

// ==== verilog/tcdm_id_reflector.sv ====
// id reflector at the zero-latency bank boundary that returns each request tag with its response
module tcdm_id_reflector
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  tcdm_req_t  req_i,
  input  tcdm_id_t   id_i,
  input  logic       gnt_i,
  input  tcdm_resp_t resp_i,
  input  logic       r_ready_i,
  output tcdm_req_t  req_o,
  output tcdm_resp_t resp_o
);

  tcdm_id_t id_q;
  logic     accept;
  logic     stall;

  // bank sees the request untouched while the tag stays here
  assign req_o  = req_i;

  assign accept = req_i.req & gnt_i;
  // response waiting on a port that is not ready
  assign stall  = resp_i.r_valid & ~r_ready_i;

  // tag register
  // loaded on every accepted request, the bank grants nothing while a response stalls
  // clear only once no response is outstanding, else it would be misrouted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (accept) begin
      id_q <= id_i;
    end else if (clear_i && !stall) begin
      id_q <= '0;
    end
  end

  // bank answer with the held tag attached
  assign resp_o.r_valid = resp_i.r_valid;
  assign resp_o.r_data  = resp_i.r_data;
  assign resp_o.r_id    = id_q;

endmodule

// ==== verilog/tcdm_bank.sv ====
// single-port word memory with byte enables, one-cycle response and response hold register
module tcdm_bank
  import tcdm_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 1024,
  parameter int unsigned IDX_W     = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  tcdm_req_t  req_i,
  output logic       gnt_o,
  output tcdm_resp_t resp_o,
  input  logic       r_ready_i
);

  tcdm_data_t        mem [MEM_WORDS];
  logic              r_valid_q;
  tcdm_data_t        r_data_q;
  logic              pending;
  logic              hs;
  logic [IDX_W-1:0]  idx;

  // low address bits select the word
  assign idx     = req_i.add[IDX_W-1:0];

  // previous response still not taken
  assign pending = r_valid_q & ~r_ready_i;
  // a released response frees the bank in the same cycle
  assign gnt_o   = req_i.req & ~pending;
  assign hs      = req_i.req & gnt_o;

  // byte-enabled write, wen low means write
  always_ff @(posedge clk_i) begin
    if (hs && !req_i.wen) begin
      for (int b = 0; b < BE_W; b++) begin
        if (req_i.be[b]) begin
          mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
        end
      end
    end
  end

  // response payload
  // reads return the old word, writes echo the write data
  always_ff @(posedge clk_i) begin
    if (hs) begin
      r_data_q <= req_i.wen ? mem[idx] : req_i.data;
    end
  end

  // response valid, held until the owner is ready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (hs) begin
      r_valid_q <= 1'b1;
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  assign resp_o.r_valid = r_valid_q;
  assign resp_o.r_data  = r_data_q;
  // tag is added by the reflector
  assign resp_o.r_id    = '0;

endmodule

// ==== verilog/tcdm_mux_top.sv ====
// N-to-1 tcdm multiplexer top level with arbitration, steering, id reflector and memory bank
module tcdm_mux_top
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_CHAN   = 4,
  parameter int unsigned MEM_WORDS = 1024,
  parameter int unsigned CH_W      = (NB_CHAN > 1) ? $clog2(NB_CHAN) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          priority_force_i,
  input  logic       [NB_CHAN-1:0][CH_W-1:0] priority_i,
  input  tcdm_req_t  [NB_CHAN-1:0]      in_req_i,
  output logic       [NB_CHAN-1:0]      in_gnt_o,
  output tcdm_resp_t [NB_CHAN-1:0]      in_resp_o,
  input  logic       [NB_CHAN-1:0]      in_r_ready_i
);

  logic [NB_CHAN-1:0] req_bits;
  logic [CH_W-1:0]    winner;
  tcdm_req_t          steer_req, bank_req;
  tcdm_id_t           steer_id;
  tcdm_resp_t         bank_resp, refl_resp;
  logic               bank_gnt;
  logic               r_ready;
  logic               out_hs;

  // the controller only needs the req bits
  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_req_bits
    assign req_bits[i] = in_req_i[i].req;
  end

  // handshake at the bank port advances the rotation
  assign out_hs = bank_req.req & bank_gnt;

  tcdm_arb_ctrl #(.NB_CHAN(NB_CHAN), .CH_W(CH_W)) i_ctrl (
    .clk_i, .rst_ni, .clear_i, .priority_force_i, .priority_i,
    .req_i(req_bits), .out_hs_i(out_hs), .winner_o(winner)
  );

  tcdm_port_steer #(.NB_CHAN(NB_CHAN), .CH_W(CH_W)) i_steer (
    .winner_i(winner), .in_req_i, .in_r_ready_i, .in_gnt_o, .in_resp_o,
    .out_gnt_i(bank_gnt), .out_resp_i(refl_resp), .out_req_o(steer_req),
    .out_id_o(steer_id), .out_r_ready_o(r_ready)
  );

  tcdm_id_reflector i_refl (
    .clk_i, .rst_ni, .clear_i, .req_i(steer_req), .id_i(steer_id),
    .gnt_i(bank_gnt), .resp_i(bank_resp), .r_ready_i(r_ready),
    .req_o(bank_req), .resp_o(refl_resp)
  );

  tcdm_bank #(.MEM_WORDS(MEM_WORDS)) i_bank (
    .clk_i, .rst_ni, .req_i(bank_req), .gnt_o(bank_gnt),
    .resp_o(bank_resp), .r_ready_i(r_ready)
  );

endmodule

// ==== sim/tb_clk_gen.sv ====
// testbench clock generator with a 20 ns period and a 3-cycle active-low reset
module tb_clk_gen #(
  parameter int unsigned HALF_NS    = 10,
  parameter int unsigned RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  // reset released on a falling edge, like the rest of the stimulus
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== sim/tcdm_mux_properties.sv ====
// concurrent handshake assertions bound to the tcdm multiplexer top level
module tcdm_mux_properties
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_CHAN = 4
) (
  input logic                     clk_i,
  input logic                     rst_ni,
  input tcdm_req_t  [NB_CHAN-1:0] in_req_i,
  input logic       [NB_CHAN-1:0] in_gnt_o,
  input tcdm_resp_t [NB_CHAN-1:0] in_resp_o,
  input logic       [NB_CHAN-1:0] in_r_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [NB_CHAN-1:0] r_valid;

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_port
    assign r_valid[i] = in_resp_o[i].r_valid;

    // initiator keeps the whole request until granted
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_req_i[i].req && !in_gnt_o[i] |=> $stable(in_req_i[i]))
      else $error("request at port %0d changed before its grant", i);

    // stalled response keeps valid, data and tag
    a_resp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid[i] && !in_r_ready_i[i] |=> r_valid[i] && $stable(in_resp_o[i]))
      else $error("held response at port %0d changed before ready", i);
  end

  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(in_gnt_o))
    else $error("more than one grant in a cycle");

  a_one_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(r_valid))
    else $error("more than one response valid in a cycle");

endmodule

bind tcdm_mux_top tcdm_mux_properties #(.NB_CHAN(NB_CHAN)) i_props (.*);

// ==== sim/tcdm_mux_tb.sv ====
// tcdm multiplexer testbench with stimulus, lfsr, reference model, checks and summary
module tcdm_mux_tb
  import tcdm_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NB_CHAN   = 4;
  localparam int unsigned MEM_WORDS = 1024;
  localparam int unsigned CH_W      = 2;
  // transactions over all tests
  // four cycles each plus reset and hold time
  localparam int TOTAL_TXN = 32 + 40 + 24 + 40 + 10 + 32;
  localparam int LIMIT     = TOTAL_TXN * 4 + 40;

  logic clk, rst_n;
  tcdm_req_t  [NB_CHAN-1:0]           req_drv    = '0;
  logic       [NB_CHAN-1:0]           gnt;
  tcdm_resp_t [NB_CHAN-1:0]           resp;
  logic       [NB_CHAN-1:0]           r_ready    = '1;
  logic                               clear      = 1'b0;
  logic                               prio_force = 1'b0;
  logic       [NB_CHAN-1:0][CH_W-1:0] prio_tab   = '0;

  // stimulus state
  int         target [NB_CHAN];
  int         issued [NB_CHAN];
  int         granted [NB_CHAN];
  int         resp_cnt [NB_CHAN];
  tcdm_req_t  cur [NB_CHAN];
  bit         rnd_issue, wr_only, pre_mode;
  bit         lat_chk = 1'b1;
  tcdm_addr_t pre_addr = '0;
  logic [19:0] lfsr_q = 20'd71146;

  // reference model state
  tcdm_data_t ref_mem [MEM_WORDS];
  tcdm_data_t exp_q [NB_CHAN][$];
  int         cyc_q [NB_CHAN][$];
  int         ref_cnt, ref_win_q;
  // port of the last grant, the bank holds one response at a time
  int         resp_owner;
  bit         ref_hs_q, ref_any_q, after_clear;
  int         cyc, gnt_total, err_cnt, proc_err, n_checks, n_tests;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  tcdm_mux_top #(.NB_CHAN(NB_CHAN), .MEM_WORDS(MEM_WORDS)) i_dut (
    .clk_i(clk), .rst_ni(rst_n), .clear_i(clear), .priority_force_i(prio_force),
    .priority_i(prio_tab), .in_req_i(req_drv), .in_gnt_o(gnt), .in_resp_o(resp),
    .in_r_ready_i(r_ready)
  );

  // fibonacci lfsr with taps x^20 + x^17 + 1
  // stepped once for every bit returned
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[19] ^ lfsr_q[16];
      lfsr_q = {lfsr_q[18:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic tcdm_req_t gen_req();
    tcdm_req_t r;
    r.req  = 1'b1;
    r.add  = tcdm_addr_t'(rand_bits(4));
    r.wen  = wr_only ? 1'b0 : 1'(rand_bits(1));
    r.be   = tcdm_be_t'(rand_bits(BE_W));
    r.data = tcdm_data_t'(rand_bits(DATA_W));
    // preload fills the address window with full words
    if (pre_mode) begin
      r.add = pre_addr;
      r.wen = 1'b0;
      r.be  = '1;
    end
    return r;
  endfunction

  // memory model
  // reads give the stored word and writes echo their data
  function automatic tcdm_data_t ref_access(tcdm_req_t r);
    if (r.wen) begin
      return ref_mem[r.add];
    end
    for (int b = 0; b < BE_W; b++) begin
      if (r.be[b]) begin
        ref_mem[r.add][8*b +: 8] = r.data[8*b +: 8];
      end
    end
    return r.data;
  endfunction

  // lowest-rank requester, rank order rotated by the counter or from the table
  function automatic int ref_winner(logic [NB_CHAN-1:0] mask);
    int ch;
    if (ref_hs_q || !ref_any_q) begin
      for (int r = 0; r < NB_CHAN; r++) begin
        ch = prio_force ? int'(prio_tab[r]) : (ref_cnt + r) % NB_CHAN;
        if (mask[ch]) begin
          return ch;
        end
      end
      return ref_cnt;
    end
    return ref_win_q;
  endfunction

  task automatic check_data(string name, tcdm_data_t got, tcdm_data_t exp);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_id(string name, tcdm_id_t got, tcdm_id_t exp);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_gnt(string name, logic [NB_CHAN-1:0] got, logic [NB_CHAN-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_error(string msg);
    err_cnt++;
    $display("error: %s", msg);
  endtask

  // new requests go out on the falling edge and stay until granted
  always @(negedge clk) begin
    for (int i = 0; i < NB_CHAN; i++) begin
      if (issued[i] == granted[i] && issued[i] < target[i]) begin
        if (!rnd_issue || rand_bits(1) == 32'd1) begin
          cur[i] = gen_req();
          issued[i]++;
          if (pre_mode) pre_addr = pre_addr + 1'b1;
        end
      end
      req_drv[i] <= (issued[i] != granted[i]) ? cur[i] : '0;
    end
  end

  // responses and grants are sampled on the rising edge
  always @(posedge clk) begin : compare
    logic [NB_CHAN-1:0] mask, exp_gnt;
    logic               pend;
    int                 w;
    tcdm_data_t         e;
    int                 gc;
    if (rst_n) begin
      for (int i = 0; i < NB_CHAN; i++) begin
        if (resp[i].r_valid && r_ready[i]) begin
          if (exp_q[i].size() == 0) begin
            report_error($sformatf("unexpected response at port %0d", i));
          end else begin
            e  = exp_q[i].pop_front();
            gc = cyc_q[i].pop_front();
            check_data($sformatf("in_resp_o[%0d].r_data", i), resp[i].r_data, e);
            check_id($sformatf("in_resp_o[%0d].r_id", i), resp[i].r_id,
                     tcdm_id_t'(resp_owner));
            if (lat_chk && cyc != gc + 1) begin
              report_error($sformatf("response at port %0d not one cycle after grant", i));
            end
            resp_cnt[i]++;
          end
        end
      end
      pend = 1'b0;
      for (int i = 0; i < NB_CHAN; i++) begin
        mask[i] = req_drv[i].req;
        if (resp[i].r_valid && !r_ready[i]) pend = 1'b1;
      end
      w       = ref_winner(mask);
      exp_gnt = '0;
      if (!pend && mask != '0) exp_gnt[w] = 1'b1;
      check_gnt("in_gnt_o", gnt, exp_gnt);
      // after a clear the next grant restarts at port 0
      if (after_clear && gnt != '0) begin
        check_gnt("in_gnt_o after clear", gnt, NB_CHAN'(1));
        after_clear = 1'b0;
      end
      for (int i = 0; i < NB_CHAN; i++) begin
        if (gnt[i]) begin
          exp_q[i].push_back(ref_access(req_drv[i]));
          cyc_q[i].push_back(cyc);
          resp_owner = i;
          granted[i]++;
          gnt_total++;
        end
      end
      ref_win_q = w;
      ref_hs_q  = (exp_gnt != '0);
      ref_any_q = (mask != '0);
      if (clear) begin
        ref_cnt     = 0;
        ref_win_q   = 0;
        ref_hs_q    = 1'b0;
        ref_any_q   = 1'b0;
        after_clear = 1'b1;
      end else if (exp_gnt != '0) begin
        ref_cnt = (ref_cnt + 1) % NB_CHAN;
      end
    end
    cyc++;
    if (cyc > LIMIT) begin
      $display("timeout: run exceeded %0d cycles", LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // test flags and targets update on the rising edge
  task automatic start(logic [NB_CHAN-1:0] ports, int n, bit rnd, bit wr, bit pre);
    @(posedge clk);
    rnd_issue = rnd;
    wr_only   = wr;
    pre_mode  = pre;
    for (int i = 0; i < NB_CHAN; i++) begin
      if (ports[i]) target[i] += n;
    end
  endtask

  task automatic wait_done();
    bit done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = 1'b1;
      for (int i = 0; i < NB_CHAN; i++) begin
        if (granted[i] != target[i] || exp_q[i].size() != 0) done = 1'b0;
      end
    end
  endtask

  task automatic end_test(string name, int err_before);
    int errs;
    errs = err_cnt + proc_err - err_before;
    n_tests++;
    $display("test %0d %s: %s (%0d errors)", n_tests, name, (errs == 0) ? "ok" : "bad", errs);
  endtask

  task automatic note_failure(string msg);
    proc_err++;
    $display("error: %s", msg);
  endtask

  initial begin
    int e0, g0, r0;
    @(posedge rst_n);
    // rotation from port 0 after reset with writes only
    e0 = err_cnt + proc_err;
    start(4'b1111, 8, 1'b0, 1'b1, 1'b0);
    wait_done();
    end_test("round-robin rotation", e0);
    // single port preloads the window before mixed traffic
    e0 = err_cnt + proc_err;
    start(4'b0001, 16, 1'b0, 1'b1, 1'b1);
    wait_done();
    start(4'b0001, 24, 1'b0, 1'b0, 1'b0);
    wait_done();
    end_test("single port read/write", e0);
    // rank 0 is port 2, then 0, 3, 1
    e0 = err_cnt + proc_err;
    @(negedge clk);
    prio_force  = 1'b1;
    prio_tab[0] = 2'd2;
    prio_tab[1] = 2'd0;
    prio_tab[2] = 2'd3;
    prio_tab[3] = 2'd1;
    start(4'b1111, 6, 1'b1, 1'b0, 1'b0);
    wait_done();
    @(negedge clk);
    prio_force = 1'b0;
    end_test("forced priority", e0);
    e0 = err_cnt + proc_err;
    start(4'b1111, 10, 1'b1, 1'b0, 1'b0);
    wait_done();
    end_test("random masks", e0);
    // back-pressure on port 1
    e0 = err_cnt + proc_err;
    @(negedge clk);
    r_ready[1] = 1'b0;
    lat_chk    = 1'b0;
    r0         = resp_cnt[1];
    start(4'b0010, 1, 1'b0, 1'b0, 1'b0);
    while (granted[1] != target[1]) @(negedge clk);
    start(4'b1101, 3, 1'b0, 1'b0, 1'b0);
    g0 = gnt_total;
    repeat (5) @(negedge clk);
    if (gnt_total != g0) note_failure("grant given while a response was held");
    if (!resp[1].r_valid) note_failure("held response at port 1 disappeared");
    if (resp_cnt[1] != r0) note_failure("port 1 took a response while not ready");
    r_ready[1] = 1'b1;
    wait_done();
    if (resp_cnt[1] != r0 + 1) note_failure("port 1 did not get exactly one response");
    lat_chk = 1'b1;
    end_test("back-pressure", e0);
    // clear in the middle of contended traffic
    e0 = err_cnt + proc_err;
    start(4'b1111, 8, 1'b0, 1'b0, 1'b0);
    g0 = gnt_total;
    while (gnt_total < g0 + 2) @(negedge clk);
    clear = 1'b1;
    @(negedge clk);
    clear = 1'b0;
    wait_done();
    end_test("clear during traffic", e0);
    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks,
             err_cnt + proc_err);
    if (err_cnt + proc_err == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== all.f ====
verilog/tcdm_pkg.sv
verilog/tcdm_arb_ctrl.sv
verilog/tcdm_port_steer.sv
verilog/tcdm_id_reflector.sv
verilog/tcdm_bank.sv
verilog/tcdm_mux_top.sv
sim/tb_clk_gen.sv
sim/tcdm_mux_properties.sv
sim/tcdm_mux_tb.sv

// ==== Makefile ====
TOP := tcdm_mux_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -Mdir obj_dir -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "\*\*\* TEST PASSED \*\*\*"

clean:
	rm -rf obj_dir
